//--- verilog/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ************************************************************
// Fetch stage 2 sizing
// ************************************************************

// Address and instruction widths
`define FS_PC_W        32
`define FS_INST_W      32

// Fetch width and byte step between neighbouring lanes
`define FS_LANES       4
`define FS_INST_BYTES  4

// CTI queue, the tag width covers the whole depth
`define FS_CTIQ_DEPTH  16
`define FS_CTIQ_TAG_W  4

`endif

//--- verilog/fetchPkg.sv
`include "fetch_config.svh"

package fetchPkg;

  // Control-transfer instruction class, a conditional branch is the only one that can fall through
  typedef enum logic [1:0] {
    CTI_RETURN = 2'b00,
    CTI_CALL   = 2'b01,
    CTI_JUMP   = 2'b10,
    CTI_COND   = 2'b11
  } ctiType_t;

  typedef struct packed {
    logic                btbHit;
    logic [`FS_PC_W-1:0] btbTarget;
    logic                prediction;   // Direction predictor says taken
  } laneIn_t;

  typedef struct packed {
    logic                isCti;
    ctiType_t            ctiType;
    logic [`FS_PC_W-1:0] target;       // PC relative target
  } laneDecode_t;

  typedef struct packed {
    logic [`FS_INST_W-1:0]     instruction;
    logic [`FS_PC_W-1:0]       pc;
    logic [`FS_PC_W-1:0]       target;
    logic [`FS_CTIQ_TAG_W-1:0] ctiTag;
    logic                      prediction;
  } instPacket_t;

  typedef struct packed {
    instPacket_t [`FS_LANES-1:0] packet;
    logic [`FS_LANES-1:0]        laneValid;
  } fetchBundle_t;

  typedef struct packed {
    logic                      valid;
    logic [`FS_CTIQ_TAG_W-1:0] tag;
    logic [`FS_PC_W-1:0]       actualTarget;
    logic                      taken;
    logic                      recover;   // Execute found a mispredict at this tag
  } resolve_t;

  typedef struct packed {
    logic [`FS_PC_W-1:0] pc;
    logic [`FS_PC_W-1:0] target;
    ctiType_t            ctiType;
    logic                taken;
  } btbUpdate_t;

  typedef struct packed {
    logic                valid;
    logic [`FS_PC_W-1:0] target;
    logic                isReturn;
    logic                isCall;
    logic [`FS_PC_W-1:0] callPc;
  } redirect_t;

endpackage

//--- verilog/preDecode.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module preDecode
  import fetchPkg::*;
(
  input  logic [`FS_PC_W-1:0]   pc_i,
  input  logic [`FS_INST_W-1:0] instruction_i,
  output laneDecode_t           decode_o
);

  localparam int OffsetW = 16;

  logic [5:0]          opcode;
  logic [`FS_PC_W-1:0] offset;

  assign opcode = instruction_i[`FS_INST_W-1 -: 6];

  // Word offset, sign extended and turned into bytes
  assign offset = {{(`FS_PC_W-OffsetW-2){instruction_i[OffsetW-1]}},
                   instruction_i[OffsetW-1:0], 2'b00};

  // ************************************************************
  // Opcode classification
  // ************************************************************

  always_comb begin
    decode_o.isCti   = 1'b1;
    decode_o.ctiType = CTI_COND;
    decode_o.target  = pc_i + offset;   // Meaningless for returns, the RAS supplies those

    case (opcode)
      6'h08: begin
        decode_o.ctiType = CTI_RETURN;
      end
      6'h03: begin
        decode_o.ctiType = CTI_CALL;
      end
      6'h02: begin
        decode_o.ctiType = CTI_JUMP;
      end
      6'h04: begin
        decode_o.ctiType = CTI_COND;
      end
      default: begin
        decode_o.isCti = 1'b0;
      end
    endcase
  end

endmodule

//--- verilog/redirectCtrl.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module redirectCtrl
  import fetchPkg::*;
(
  input  logic                           fetchValid_i,
  input  logic                           stall_i,
  input  logic                           ctiQueueFull_i,
  input  laneIn_t     [`FS_LANES-1:0]    lanes_i,
  input  laneDecode_t [`FS_LANES-1:0]    decode_i,
  input  logic        [`FS_PC_W-1:0]     pc_i,
  input  logic        [`FS_PC_W-1:0]     rasTop_i,
  output logic        [`FS_LANES-1:0]    laneValid_o,
  output redirect_t                      redirect_o
);

  localparam int SelW = $clog2(`FS_LANES);

  logic [`FS_LANES-1:0] taken;
  logic                 found;
  logic [SelW-1:0]      sel;
  ctiType_t             selType;

  // ************************************************************
  // First taken CTI
  // ************************************************************

  always_comb begin
    for (int i = 0; i < `FS_LANES; i++) begin
      // Everything but a conditional branch always leaves the bundle
      taken[i] = decode_i[i].isCti &
                 (lanes_i[i].prediction | (decode_i[i].ctiType != CTI_COND));
    end
  end

  always_comb begin
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < `FS_LANES; i++) begin
      if (!found && taken[i]) begin
        found = 1'b1;
        sel   = SelW'(i);
      end
    end
  end

  // Lanes after the taken one belong to the wrong path
  always_comb begin
    for (int i = 0; i < `FS_LANES; i++) begin
      laneValid_o[i] = !found || (SelW'(i) <= sel);
    end
  end

  // ************************************************************
  // Redirect to fetch stage 1
  // ************************************************************

  assign selType = decode_i[sel].ctiType;

  always_comb begin
    redirect_o.isReturn = found && (selType == CTI_RETURN);
    redirect_o.isCall   = found && (selType == CTI_CALL);
    redirect_o.callPc   = pc_i + `FS_PC_W'(sel) * `FS_PC_W'(`FS_INST_BYTES);

    if (redirect_o.isReturn) begin
      redirect_o.target = rasTop_i;
    end else begin
      redirect_o.target = decode_i[sel].target;
    end

    // A BTB hit already steered stage 1 the right way
    redirect_o.valid = fetchValid_i & found & ~lanes_i[sel].btbHit &
                       ~stall_i & ~ctiQueueFull_i;
  end

endmodule

//--- verilog/ctiQueue.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module ctiQueue
  import fetchPkg::*;
(
  input  logic                                   clk,
  input  logic                                   arstN_i,
  input  logic                                   allocEn_i,
  input  logic        [`FS_LANES-1:0]            laneValid_i,
  input  laneDecode_t [`FS_LANES-1:0]            decode_i,
  input  logic        [`FS_PC_W-1:0]             pc_i,
  input  resolve_t                               resolve_i,
  input  logic                                   commit_i,
  output logic        [`FS_LANES-1:0][`FS_CTIQ_TAG_W-1:0] tags_o,
  output logic                                   full_o,
  output btbUpdate_t                             update_o,
  output logic                                   updateValid_o
);

  localparam int TagW     = `FS_CTIQ_TAG_W;
  localparam int CntW     = $clog2(`FS_CTIQ_DEPTH + 1);
  localparam int LaneCntW = $clog2(`FS_LANES + 1);

  btbUpdate_t             entries [`FS_CTIQ_DEPTH];
  logic [TagW-1:0]        head;
  logic [TagW-1:0]        tail;
  logic [CntW-1:0]        count;
  logic [`FS_LANES-1:0]   allocLane;
  logic [LaneCntW-1:0]    numAlloc;
  logic                   recover;
  logic                   push;
  logic                   pop;
  logic [TagW-1:0]        keepDiff;
  logic [CntW-1:0]        keepCount;

  // ************************************************************
  // Tag assignment by running count over CTI lanes
  // ************************************************************

  always_comb begin
    numAlloc = '0;
    for (int i = 0; i < `FS_LANES; i++) begin
      allocLane[i] = laneValid_i[i] & decode_i[i].isCti;
      tags_o[i]    = tail + TagW'(numAlloc);
      numAlloc     = numAlloc + LaneCntW'(allocLane[i]);
    end
  end

  assign full_o  = count > CntW'(`FS_CTIQ_DEPTH - `FS_LANES);
  assign recover = resolve_i.valid & resolve_i.recover;
  assign push    = allocEn_i & ~recover;   // Recovery wins over a same cycle allocation
  assign pop     = commit_i & (count != '0);

  // The recovering entry stays, so a zero distance means the queue is full
  assign keepDiff  = resolve_i.tag + 1'b1 - head;
  assign keepCount = (keepDiff == '0) ? CntW'(`FS_CTIQ_DEPTH) : CntW'(keepDiff);

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (recover) begin
        tail  <= resolve_i.tag + 1'b1;
        count <= keepCount - CntW'(pop);
      end else if (push) begin
        tail  <= tail + TagW'(numAlloc);
        count <= count + CntW'(numAlloc) - CntW'(pop);
      end else begin
        count <= count - CntW'(pop);
      end
    end
  end

  // ************************************************************
  // Entry storage
  // ************************************************************

  always_ff @(posedge clk) begin
    if (push) begin
      for (int i = 0; i < `FS_LANES; i++) begin
        if (allocLane[i]) begin
          entries[tags_o[i]].pc      <= pc_i + `FS_PC_W'(i * `FS_INST_BYTES);
          entries[tags_o[i]].target  <= decode_i[i].target;
          entries[tags_o[i]].ctiType <= decode_i[i].ctiType;
          entries[tags_o[i]].taken   <= decode_i[i].ctiType != CTI_COND;
        end
      end
    end
    if (resolve_i.valid) begin
      entries[resolve_i.tag].target <= resolve_i.actualTarget;
      entries[resolve_i.tag].taken  <= resolve_i.taken;
    end
  end

  // Head read, with a resolve of the head in the same cycle passed straight through
  always_comb begin
    update_o = entries[head];
    if (resolve_i.valid && (resolve_i.tag == head)) begin
      update_o.target = resolve_i.actualTarget;
      update_o.taken  = resolve_i.taken;
    end
  end

  assign updateValid_o = pop;

endmodule

//--- verilog/pipeReg.sv
`timescale 1ns/1ns

module pipeReg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arstN_i,
  input  logic     stall_i,
  input  logic     flush_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // ************************************************************
  // Valid bit
  // ************************************************************

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;   // Flush beats stall
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  // ************************************************************
  // Payload
  // ************************************************************

  // Only a valid payload is captured, so the last one stays visible while idle
  always_ff @(posedge clk) begin
    if (!stall_i && valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

//--- verilog/fetchStage2.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetchStage2
  import fetchPkg::*;
(
  input  logic                                  clk,
  input  logic                                  arstN_i,
  input  logic                                  fetchValid_i,
  input  logic    [`FS_PC_W-1:0]                pc_i,
  input  logic    [`FS_LANES*`FS_INST_W-1:0]    bundle_i,
  input  laneIn_t [`FS_LANES-1:0]               lanes_i,
  input  logic    [`FS_PC_W-1:0]                rasTop_i,
  input  logic                                  stall_i,
  input  logic                                  flush_i,
  input  resolve_t                              resolve_i,
  input  logic                                  commit_i,
  output fetchBundle_t                          decodeBundle_o,
  output logic                                  decodeValid_o,
  output redirect_t                             redirect_o,
  output logic                                  btbUpdateValid_o,
  output btbUpdate_t                            btbUpdate_o,
  output logic                                  ready_o,
  output logic                                  ctiQueueFull_o
);

  logic        [`FS_PC_W-1:0]                    lanePc [`FS_LANES];
  logic        [`FS_INST_W-1:0]                  inst   [`FS_LANES];
  laneDecode_t [`FS_LANES-1:0]                   decode;
  logic        [`FS_LANES-1:0]                   laneValid;
  logic        [`FS_LANES-1:0][`FS_CTIQ_TAG_W-1:0] tags;
  logic                                          ctiQueueFull;
  logic                                          accept;
  fetchBundle_t                                  bundle;
  btbUpdate_t                                    update;
  logic                                          updateValid;

  // ************************************************************
  // Per-lane predecode
  // ************************************************************

  for (genvar i = 0; i < `FS_LANES; i++) begin : gLane
    assign lanePc[i] = pc_i + `FS_PC_W'(i * `FS_INST_BYTES);
    assign inst[i]   = bundle_i[i*`FS_INST_W +: `FS_INST_W];

    preDecode u_preDecode (
      .pc_i          (lanePc[i]),
      .instruction_i (inst[i]),
      .decode_o      (decode[i])
    );
  end

  redirectCtrl u_redirectCtrl (
    .fetchValid_i   (fetchValid_i),
    .stall_i        (stall_i),
    .ctiQueueFull_i (ctiQueueFull),
    .lanes_i        (lanes_i),
    .decode_i       (decode),
    .pc_i           (pc_i),
    .rasTop_i       (rasTop_i),
    .laneValid_o    (laneValid),
    .redirect_o     (redirect_o)
  );

  assign ready_o        = fetchValid_i & ~ctiQueueFull;
  assign accept         = ready_o & ~stall_i;
  assign ctiQueueFull_o = ctiQueueFull;

  ctiQueue u_ctiQueue (
    .clk           (clk),
    .arstN_i       (arstN_i),
    .allocEn_i     (accept),
    .laneValid_i   (laneValid),
    .decode_i      (decode),
    .pc_i          (pc_i),
    .resolve_i     (resolve_i),
    .commit_i      (commit_i),
    .tags_o        (tags),
    .full_o        (ctiQueueFull),
    .update_o      (update),
    .updateValid_o (updateValid)
  );

  // ************************************************************
  // Bundle to decode
  // ************************************************************

  always_comb begin
    bundle.laneValid = laneValid;
    for (int i = 0; i < `FS_LANES; i++) begin
      bundle.packet[i].instruction = inst[i];
      bundle.packet[i].pc          = lanePc[i];
      bundle.packet[i].ctiTag      = tags[i];
      bundle.packet[i].prediction  = lanes_i[i].prediction;
      // Returns carry the RAS top so execute can check it
      if (decode[i].isCti && (decode[i].ctiType == CTI_RETURN)) begin
        bundle.packet[i].target = rasTop_i;
      end else begin
        bundle.packet[i].target = decode[i].target;
      end
    end
  end

  pipeReg #(.payload_t(fetchBundle_t)) u_decodeReg (
    .clk     (clk),
    .arstN_i (arstN_i),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .valid_i (accept),
    .data_i  (bundle),
    .valid_o (decodeValid_o),
    .data_o  (decodeBundle_o)
  );

  pipeReg #(.payload_t(btbUpdate_t)) u_updateReg (
    .clk     (clk),
    .arstN_i (arstN_i),
    .stall_i (1'b0),
    .flush_i (1'b0),
    .valid_i (updateValid),
    .data_i  (update),
    .valid_o (btbUpdateValid_o),
    .data_o  (btbUpdate_o)
  );

endmodule

//--- test/fetchStage2_asserts.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetchStage2_asserts
  import fetchPkg::*;
(
  input logic                 clk,
  input logic                 arstN_i,
  input logic                 stall_i,
  input redirect_t            redirect_i,
  input logic [`FS_LANES-1:0] laneValid_i,
  input logic                 decodeValid_i
);

  // ************************************************************
  // Output properties
  // ************************************************************

  // Stage 1 must not be steered by a bundle that is being held
  property noRedirectInStall;
    @(posedge clk) disable iff (!arstN_i) stall_i |-> !redirect_i.valid;
  endproperty

  property laneValidRun;   // Lane 0 always survives, no gaps after it
    @(posedge clk) disable iff (!arstN_i) laneValid_i[0] && $onehot0(laneValid_i + 1'b1);
  endproperty

  property decodeIdleAfterReset;
    @(posedge clk) $rose(arstN_i) |-> !decodeValid_i;
  endproperty

  assert property (noRedirectInStall) else $error("Redirect raised while stall_i is high");
  assert property (laneValidRun) else $error("Lane valid vector is not a run from lane 0");
  assert property (decodeIdleAfterReset) else $error("Decode valid set right after reset");

endmodule

bind fetchStage2 fetchStage2_asserts u_asserts (
  .clk           (clk),
  .arstN_i       (arstN_i),
  .stall_i       (stall_i),
  .redirect_i    (redirect_o),
  .laneValid_i   (laneValid),
  .decodeValid_i (decodeValid_o)
);

//--- test/fetchStage2_tb.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetchStage2_tb
  import fetchPkg::*;
();

  localparam int ClkPeriod  = 100;
  localparam int Depth      = `FS_CTIQ_DEPTH;
  localparam int TestCycles = 60;   // Reset plus one cycle per bundle, commit and resolve
  localparam int Margin     = 40;
  localparam logic [5:0] OpReturn = 6'h08;
  localparam logic [5:0] OpCall   = 6'h03;
  localparam logic [5:0] OpJump   = 6'h02;
  localparam logic [5:0] OpCond   = 6'h04;

  logic                           clk = 1'b0;
  logic                           arstN_i;
  logic                           fetchValid_i;
  logic [`FS_PC_W-1:0]            pc_i;
  logic [`FS_LANES*`FS_INST_W-1:0] bundle_i;
  laneIn_t [`FS_LANES-1:0]        lanes_i;
  logic [`FS_PC_W-1:0]            rasTop_i;
  logic                           stall_i;
  logic                           flush_i;
  resolve_t                       resolve_i;
  logic                           commit_i;
  fetchBundle_t                   decodeBundle_o;
  logic                           decodeValid_o;
  redirect_t                      redirect_o;
  logic                           btbUpdateValid_o;
  btbUpdate_t                     btbUpdate_o;
  logic                           ready_o;
  logic                           ctiQueueFull_o;

  // Stimulus for the next bundle and the reference model state
  logic [31:0]  laneInst [`FS_LANES];
  logic [3:0]   lanePred;
  logic [3:0]   laneHit;
  logic         stallNow;
  logic         flushNow;
  logic         prevDecValid;
  fetchBundle_t expBundle;
  logic [31:0]  mPc [Depth];
  logic [31:0]  mTarget [Depth];
  logic [1:0]   mType [Depth];
  logic         mTaken [Depth];
  logic         mResolved [Depth];
  logic [3:0]   mHead;
  logic [3:0]   mTail;
  int           mCount;
  int           errCount;
  string        curTest;
  int unsigned  seedVal;

  fetchStage2 u_dut (.*);

  always #(ClkPeriod / 2) clk = ~clk;

  // ************************************************************
  // Reference model helpers
  // ************************************************************

  function automatic logic [2:0] classify(input logic [31:0] inst);
    case (inst[31:26])
      OpReturn: return {1'b1, CTI_RETURN};
      OpCall:   return {1'b1, CTI_CALL};
      OpJump:   return {1'b1, CTI_JUMP};
      OpCond:   return {1'b1, CTI_COND};
      default:  return 3'b000;
    endcase
  endfunction

  function automatic logic [31:0] branchTarget(input logic [31:0] lanePc, input logic [31:0] inst);
    return lanePc + {{14{inst[15]}}, inst[15:0], 2'b00};
  endfunction

  function automatic logic [31:0] makeCti(input logic [5:0] op, input logic [15:0] offs);
    return {op, 10'h000, offs};
  endfunction

  function automatic logic [31:0] randomPlain();
    return $urandom | 32'h8000_0000;   // Opcode at 6'h20 or above is never a CTI
  endfunction

  task automatic check(input string name, input logic [63:0] expVal, input logic [63:0] actVal);
    if (expVal !== actVal) begin
      errCount++;
      $display("FAIL %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
      $display("Test failures found");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic idleInputs();
    fetchValid_i = 1'b0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    commit_i     = 1'b0;
    resolve_i    = '0;
  endtask

  task automatic setPlainLanes();
    for (int i = 0; i < `FS_LANES; i++) begin
      laneInst[i] = randomPlain();
    end
    lanePred = '0;
    laneHit  = '0;
  endtask

  task automatic compareBundle();
    logic [2:0] cls;
    check({curTest, " laneValid"}, expBundle.laneValid, decodeBundle_o.laneValid);
    for (int i = 0; i < `FS_LANES; i++) begin
      cls = classify(expBundle.packet[i].instruction);
      if (expBundle.laneValid[i]) begin
        check({curTest, " instruction"}, expBundle.packet[i].instruction,
              decodeBundle_o.packet[i].instruction);
        check({curTest, " pc"}, expBundle.packet[i].pc, decodeBundle_o.packet[i].pc);
        check({curTest, " prediction"}, expBundle.packet[i].prediction,
              decodeBundle_o.packet[i].prediction);
        if (cls[2]) begin
          check({curTest, " target"}, expBundle.packet[i].target,
                decodeBundle_o.packet[i].target);
          check({curTest, " ctiTag"}, expBundle.packet[i].ctiTag,
                decodeBundle_o.packet[i].ctiTag);
        end
      end
    end
  endtask

  // ************************************************************
  // Bundle, commit and resolve drivers
  // ************************************************************

  task automatic sendBundle(input logic [31:0] pc, input logic [31:0] ras);
    logic [2:0]  cls [`FS_LANES];
    logic [3:0]  expValid;
    logic        expReady;
    logic        expAccept;
    logic        expRedir;
    logic        expDec;
    logic [31:0] lanePc;
    int          first;
    @(negedge clk);
    idleInputs();
    fetchValid_i = 1'b1;
    pc_i         = pc;
    rasTop_i     = ras;
    stall_i      = stallNow;
    flush_i      = flushNow;
    first        = -1;
    for (int i = 0; i < `FS_LANES; i++) begin
      bundle_i[i*`FS_INST_W +: `FS_INST_W] = laneInst[i];
      lanes_i[i].btbHit     = laneHit[i];
      lanes_i[i].btbTarget  = $urandom;
      lanes_i[i].prediction = lanePred[i];
      cls[i] = classify(laneInst[i]);
      if (first < 0 && cls[i][2] && (lanePred[i] || cls[i][1:0] != CTI_COND)) begin
        first = i;
      end
    end
    for (int i = 0; i < `FS_LANES; i++) begin
      expValid[i] = (first < 0) || (i <= first);
    end
    expReady  = mCount <= Depth - `FS_LANES;
    expAccept = expReady && !stallNow;
    expRedir  = (first >= 0) && expReady && !stallNow && !laneHit[first];
    #10;
    check({curTest, " ready"}, expReady, ready_o);
    check({curTest, " queueFull"}, !expReady, ctiQueueFull_o);
    check({curTest, " redirect.valid"}, expRedir, redirect_o.valid);
    if (expRedir) begin
      lanePc = pc + 32'(first * `FS_INST_BYTES);
      check({curTest, " redirect.target"},
            (cls[first][1:0] == CTI_RETURN) ? ras : branchTarget(lanePc, laneInst[first]),
            redirect_o.target);
      check({curTest, " redirect.isReturn"}, cls[first][1:0] == CTI_RETURN, redirect_o.isReturn);
      check({curTest, " redirect.isCall"}, cls[first][1:0] == CTI_CALL, redirect_o.isCall);
      check({curTest, " redirect.callPc"}, lanePc, redirect_o.callPc);
    end
    if (expAccept) begin
      expBundle.laneValid = expValid;
      for (int i = 0; i < `FS_LANES; i++) begin
        lanePc = pc + 32'(i * `FS_INST_BYTES);
        expBundle.packet[i].instruction = laneInst[i];
        expBundle.packet[i].pc          = lanePc;
        expBundle.packet[i].prediction  = lanePred[i];
        expBundle.packet[i].target      = (cls[i] == {1'b1, CTI_RETURN}) ?
                                          ras : branchTarget(lanePc, laneInst[i]);
        expBundle.packet[i].ctiTag      = '0;
        if (expValid[i] && cls[i][2]) begin
          expBundle.packet[i].ctiTag = mTail;
          mPc[mTail]       = lanePc;
          mType[mTail]     = cls[i][1:0];
          mResolved[mTail] = 1'b0;
          mTail            = mTail + 4'd1;
          mCount++;
        end
      end
    end
    @(posedge clk);
    #10;
    if (flushNow) begin
      expDec = 1'b0;
    end else if (stallNow) begin
      expDec = prevDecValid;   // Register holds its contents
    end else begin
      expDec = expAccept;
    end
    prevDecValid = expDec;
    check({curTest, " decodeValid"}, expDec, decodeValid_o);
    if (expDec) begin
      compareBundle();
    end
  endtask

  task automatic commitOne();
    logic       expUpd;
    logic [3:0] h;
    @(negedge clk);
    idleInputs();
    commit_i = 1'b1;
    expUpd   = mCount > 0;
    h        = mHead;
    @(posedge clk);
    #10;
    prevDecValid = 1'b0;
    check({curTest, " btbUpdateValid"}, expUpd, btbUpdateValid_o);
    if (expUpd) begin
      check({curTest, " update.pc"}, mPc[h], btbUpdate_o.pc);
      check({curTest, " update.ctiType"}, mType[h], btbUpdate_o.ctiType);
      if (mResolved[h]) begin
        check({curTest, " update.target"}, mTarget[h], btbUpdate_o.target);
        check({curTest, " update.taken"}, mTaken[h], btbUpdate_o.taken);
      end
      mHead = mHead + 4'd1;
      mCount--;
    end
  endtask

  task automatic resolveOne(input logic [3:0] tag, input logic [31:0] target,
                            input logic taken, input logic recover);
    logic [3:0] keep;
    @(negedge clk);
    idleInputs();
    resolve_i.valid        = 1'b1;
    resolve_i.tag          = tag;
    resolve_i.actualTarget = target;
    resolve_i.taken        = taken;
    resolve_i.recover      = recover;
    @(posedge clk);
    #10;
    prevDecValid   = 1'b0;
    mTarget[tag]   = target;
    mTaken[tag]    = taken;
    mResolved[tag] = 1'b1;
    if (recover) begin
      keep   = tag + 4'd1 - mHead;   // The recovering entry itself is kept
      mTail  = tag + 4'd1;
      mCount = (keep == 4'd0) ? Depth : keep;
    end
    check({curTest, " queueFull"}, mCount > Depth - `FS_LANES, ctiQueueFull_o);
  endtask

  task automatic drainQueue();
    while (mCount > 0) begin
      commitOne();
    end
  endtask

  // ************************************************************
  // Directed tests
  // ************************************************************

  task automatic testNoCti();
    curTest = "noCti";
    setPlainLanes();
    lanePred = 4'($urandom);
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
  endtask

  task automatic testCondTaken();
    curTest = "condTaken";
    setPlainLanes();
    laneInst[1] = makeCti(OpCond, 16'hFFF0);
    lanePred[1] = 1'b1;
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    laneHit[1] = 1'b1;   // Second pass hits in the BTB
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
  endtask

  task automatic testReturnCall();
    curTest = "returnCall";
    setPlainLanes();
    laneInst[2] = makeCti(OpReturn, 16'($urandom));
    laneInst[3] = makeCti(OpJump, 16'h0020);
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom & 32'hFFFF_FFFC);
    setPlainLanes();
    laneInst[0] = makeCti(OpCall, 16'h0040);
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
  endtask

  task automatic testNotTakenPair();
    logic [3:0] t;
    curTest = "notTakenPair";
    drainQueue();
    setPlainLanes();
    laneInst[0] = makeCti(OpCond, 16'h0100);
    laneInst[3] = makeCti(OpCond, 16'h8000);
    t = mTail;
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    resolveOne(t, 32'h0000_4400, 1'b1, 1'b0);
    resolveOne(t + 4'd1, 32'h0000_8800, 1'b0, 1'b0);
    commitOne();
    commitOne();
  endtask

  task automatic testFullStall();
    curTest = "fullStall";
    for (int b = 0; b < 4; b++) begin
      setPlainLanes();
      for (int i = 0; i < `FS_LANES; i++) begin
        laneInst[i] = makeCti(OpCond, 16'($urandom));
      end
      sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    end
    setPlainLanes();
    laneInst[0] = makeCti(OpJump, 16'h0200);   // Redirect must be held back while full
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    repeat (4) commitOne();
    setPlainLanes();
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    stallNow    = 1'b1;
    laneInst[0] = makeCti(OpJump, 16'h0300);
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    flushNow = 1'b1;
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    stallNow = 1'b0;
    flushNow = 1'b0;
  endtask

  task automatic testRecovery();
    logic [3:0] t;
    curTest = "recovery";
    drainQueue();
    t = mTail;
    setPlainLanes();
    for (int i = 0; i < `FS_LANES; i++) begin
      laneInst[i] = makeCti(OpCond, 16'($urandom));
    end
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    setPlainLanes();
    laneInst[1] = makeCti(OpCond, 16'h0010);
    laneInst[2] = makeCti(OpCond, 16'h0020);
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    resolveOne(t, 32'h0001_0000, 1'b1, 1'b0);
    resolveOne(t + 4'd1, 32'h0002_0000, 1'b0, 1'b1);   // Drops four younger entries
    setPlainLanes();
    laneInst[0] = makeCti(OpCond, 16'h0004);
    sendBundle($urandom & 32'hFFFF_FFF0, $urandom);
    resolveOne(t + 4'd2, 32'h0003_0000, 1'b1, 1'b0);
    repeat (4) commitOne();   // The last one finds the queue empty
  endtask

  // ************************************************************
  // Run control
  // ************************************************************

  initial begin
    #((TestCycles + Margin) * ClkPeriod);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Test failures found");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    seedVal      = 32'h204d_5c10;
    void'($urandom(seedVal));
    errCount     = 0;
    arstN_i      = 1'b0;
    pc_i         = '0;
    bundle_i     = '0;
    lanes_i      = '0;
    rasTop_i     = '0;
    stallNow     = 1'b0;
    flushNow     = 1'b0;
    prevDecValid = 1'b0;
    mHead        = '0;
    mTail        = '0;
    mCount       = 0;
    idleInputs();
    repeat (5) @(posedge clk);
    @(negedge clk);
    arstN_i = 1'b1;

    testNoCti();
    testCondTaken();
    testReturnCall();
    testNotTakenPair();
    testFullStall();
    testRecovery();

    @(negedge clk);
    idleInputs();
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+verilog
verilog/fetchPkg.sv
verilog/preDecode.sv
verilog/redirectCtrl.sv
verilog/ctiQueue.sv
verilog/pipeReg.sv
verilog/fetchStage2.sv
test/fetchStage2_asserts.sv
test/fetchStage2_tb.sv
